// File: verilog/rs_pkg.sv
/*
 * Reservation station package
 * Sizes and vector types shared by the entries, allocator and issue selector
 */

package rs_pkg;

    // Number of station entries and the width of an entry number or age
    localparam int RS_DEPTH      = 8;
    localparam int RS_IDX_WIDTH  = $clog2(RS_DEPTH);

    // Number of result broadcast buses feeding every entry
    localparam int CDB_DEPTH     = 2;

    // Operand data and instruction words share one width
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;

    // Reorder buffer tag width names both source and destination results
    localparam int ROB_IDX_WIDTH = 5;
    localparam int OPCODE_WIDTH  = 4;

    // Operand value or raw instruction bits
    typedef logic [DATA_WIDTH-1:0]    data_t;

    // Instruction address
    typedef logic [ADDR_WIDTH-1:0]    addr_t;

    // Reorder buffer tag
    typedef logic [ROB_IDX_WIDTH-1:0] rob_tag_t;

    // Functional unit opcode
    typedef logic [OPCODE_WIDTH-1:0]  opcode_t;

    // Entry number, also used for the relative age of an entry
    typedef logic [RS_IDX_WIDTH-1:0]  rs_idx_t;

    // One bit per station entry
    typedef logic [RS_DEPTH-1:0]      rs_mask_t;

endpackage

// File: verilog/rs_entry.sv
/*
 * Reservation station entry
 * Holds one dispatched instruction, captures its sources from the broadcast buses, tracks its age
 */

`timescale 1ns/1ps

module rs_entry
    import rs_pkg::*;
(
    input  logic     clk,
    input  logic     i_arst_n,

    input  logic     i_flush,
    input  logic     i_dispatch_en,
    input  logic     i_dispatching,
    input  logic     i_issue_en,
    input  logic     i_issuing,
    input  rs_idx_t  i_issue_age,

    input  opcode_t  i_dispatch_opcode,
    input  addr_t    i_dispatch_iaddr,
    input  data_t    i_dispatch_insn,
    input  rob_tag_t i_dispatch_src_tag  [0:1],
    input  data_t    i_dispatch_src_data [0:1],
    input  logic     i_dispatch_src_rdy  [0:1],
    input  rob_tag_t i_dispatch_dst_tag,

    input  logic     i_cdb_en   [0:CDB_DEPTH-1],
    input  rob_tag_t i_cdb_tag  [0:CDB_DEPTH-1],
    input  data_t    i_cdb_data [0:CDB_DEPTH-1],

    output logic     o_ready,
    output logic     o_empty,
    output rs_idx_t  o_age,
    output opcode_t  o_opcode,
    output addr_t    o_iaddr,
    output data_t    o_insn,
    output data_t    o_src_data [0:1],
    output rob_tag_t o_dst_tag
);

    // Control state of the entry
    logic     empty_r;
    rs_idx_t  age_r;
    logic     src_rdy_r  [0:1];

    // Payload captured at dispatch
    opcode_t  opcode_r;
    addr_t    iaddr_r;
    data_t    insn_r;
    rob_tag_t src_tag_r  [0:1];
    data_t    src_data_r [0:1];
    rob_tag_t dst_tag_r;

    logic     empty_next;
    rs_idx_t  age_next;
    logic     src_rdy_next  [0:1];
    data_t    src_data_next [0:1];

    // Tag match of each source against each broadcast bus
    logic     cdb_match [0:1][0:CDB_DEPTH-1];

    // Issue or flush frees the entry, dispatch fills it, flush wins over everything
    always_comb begin
        if (i_flush || i_issue_en) begin
            empty_next = 1'b1;
        end else if (i_dispatch_en) begin
            empty_next = 1'b0;
        end else begin
            empty_next = empty_r;
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int c = 0; c < CDB_DEPTH; c++) begin
                cdb_match[s][c] = i_cdb_en[c] && (i_cdb_tag[c] == src_tag_r[s]);
            end
        end
    end

    // Only a waiting source takes broadcast data, so a ready operand is never overwritten
    // Buses are scanned in order, which lets the higher-numbered bus win a double match
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_data_next[s] = src_data_r[s];
            src_rdy_next[s]  = src_rdy_r[s];
            for (int c = 0; c < CDB_DEPTH; c++) begin
                if (!src_rdy_r[s] && cdb_match[s][c]) begin
                    src_data_next[s] = i_cdb_data[c];
                    src_rdy_next[s]  = 1'b1;
                end
            end
            // A new instruction replaces whatever the old one held
            if (i_dispatch_en) begin
                src_data_next[s] = i_dispatch_src_data[s];
                src_rdy_next[s]  = i_dispatch_src_rdy[s];
            end
        end
    end

    // Age moves with station-wide dispatch and issue events
    // Dispatch alone ages everyone else, issue alone rejuvenates entries older than the issued one
    // With both, only entries younger than the issued one get older
    always_comb begin
        case ({i_dispatching, i_issuing})
            2'b01: age_next = (age_r > i_issue_age) ? age_r - rs_idx_t'(1) : age_r;
            2'b10: age_next = i_dispatch_en ? '0 : age_r + rs_idx_t'(1);
            2'b11: begin
                if (i_dispatch_en) begin
                    age_next = '0;
                end else begin
                    age_next = (age_r < i_issue_age) ? age_r + rs_idx_t'(1) : age_r;
                end
            end
            default: age_next = age_r;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            empty_r      <= 1'b1;
            age_r        <= '0;
            src_rdy_r[0] <= 1'b0;
            src_rdy_r[1] <= 1'b0;
        end else begin
            empty_r      <= empty_next;
            age_r        <= age_next;
            src_rdy_r[0] <= src_rdy_next[0];
            src_rdy_r[1] <= src_rdy_next[1];
        end
    end

    always_ff @(posedge clk) begin
        src_data_r[0] <= src_data_next[0];
        src_data_r[1] <= src_data_next[1];
        if (i_dispatch_en) begin
            opcode_r     <= i_dispatch_opcode;
            iaddr_r      <= i_dispatch_iaddr;
            insn_r       <= i_dispatch_insn;
            src_tag_r[0] <= i_dispatch_src_tag[0];
            src_tag_r[1] <= i_dispatch_src_tag[1];
            dst_tag_r    <= i_dispatch_dst_tag;
        end
    end

    // Ready to issue once the entry holds an instruction with both operands present
    assign o_ready    = !empty_r && src_rdy_r[0] && src_rdy_r[1];

    assign o_empty    = empty_r;
    assign o_age      = age_r;
    assign o_opcode   = opcode_r;
    assign o_iaddr    = iaddr_r;
    assign o_insn     = insn_r;
    assign o_src_data = src_data_r;
    assign o_dst_tag  = dst_tag_r;

endmodule

// File: verilog/rs_alloc.sv
/*
 * Reservation station allocator
 * Gives each dispatch the lowest empty entry and stalls dispatch when the station is full
 */

`timescale 1ns/1ps

module rs_alloc
    import rs_pkg::*;
(
    input  rs_mask_t i_entry_empty,
    input  logic     i_dispatch_en,

    output rs_mask_t o_dispatch_sel,
    output logic     o_dispatching,
    output logic     o_dispatch_stall
);

    // One-hot mark of the lowest-numbered empty entry
    rs_mask_t first_empty;
    logic     found;

    // Priority encoder from entry 0 upward
    always_comb begin
        first_empty = '0;
        found       = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (i_entry_empty[i] && !found) begin
                first_empty[i] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    // No free slot means dispatch must wait
    assign o_dispatch_stall = ~|i_entry_empty;

    // The entry enable only fires for a real request; with no free slot it is all zero
    assign o_dispatch_sel   = i_dispatch_en ? first_empty : '0;

    // Tells every entry that some dispatch is being written this cycle
    assign o_dispatching    = i_dispatch_en && found;

endmodule

// File: verilog/rs_issue_select.sv
/*
 * Reservation station issue selector
 * Picks the oldest ready entry, drives the issue port and frees the entry on acceptance
 */

`timescale 1ns/1ps

module rs_issue_select
    import rs_pkg::*;
(
    input  rs_mask_t i_entry_ready,
    input  rs_idx_t  i_entry_age      [0:RS_DEPTH-1],
    input  logic     i_issue_stall,

    input  opcode_t  i_entry_opcode   [0:RS_DEPTH-1],
    input  addr_t    i_entry_iaddr    [0:RS_DEPTH-1],
    input  data_t    i_entry_insn     [0:RS_DEPTH-1],
    input  data_t    i_entry_src_data [0:RS_DEPTH-1][0:1],
    input  rob_tag_t i_entry_dst_tag  [0:RS_DEPTH-1],

    output rs_mask_t o_issue_sel,
    output logic     o_issuing,
    output rs_idx_t  o_issue_age,

    output logic     o_issue_valid,
    output opcode_t  o_issue_opcode,
    output addr_t    o_issue_iaddr,
    output data_t    o_issue_insn,
    output data_t    o_issue_src_data [0:1],
    output rob_tag_t o_issue_dst_tag
);

    logic    any_ready;
    rs_idx_t best_idx;
    rs_idx_t best_age;

    // Ages are unique among full entries, so the strict compare gives one winner
    always_comb begin
        any_ready = 1'b0;
        best_idx  = '0;
        best_age  = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (i_entry_ready[i] && (!any_ready || (i_entry_age[i] > best_age))) begin
                any_ready = 1'b1;
                best_idx  = rs_idx_t'(i);
                best_age  = i_entry_age[i];
            end
        end
    end

    // The issue port shows the winner even under back-pressure
    assign o_issue_valid       = any_ready;
    assign o_issue_opcode      = i_entry_opcode[best_idx];
    assign o_issue_iaddr       = i_entry_iaddr[best_idx];
    assign o_issue_insn        = i_entry_insn[best_idx];
    assign o_issue_src_data[0] = i_entry_src_data[best_idx][0];
    assign o_issue_src_data[1] = i_entry_src_data[best_idx][1];
    assign o_issue_dst_tag     = i_entry_dst_tag[best_idx];

    // Entry is freed and ages adjust only when the functional unit takes the instruction
    assign o_issuing   = any_ready && !i_issue_stall;
    assign o_issue_sel = o_issuing ? (rs_mask_t'(1) << best_idx) : '0;
    assign o_issue_age = best_age;

endmodule

// File: verilog/reservation_station.sv
/*
 * Reservation station top level
 * Eight entries with dispatch allocation and oldest-ready issue to one functional unit
 */

`timescale 1ns/1ps

module reservation_station
    import rs_pkg::*;
(
    input  logic     clk,
    input  logic     i_arst_n,

    input  logic     i_flush,

    // Dispatch from the front end
    input  logic     i_dispatch_en,
    input  opcode_t  i_dispatch_opcode,
    input  addr_t    i_dispatch_iaddr,
    input  data_t    i_dispatch_insn,
    input  rob_tag_t i_dispatch_src_tag  [0:1],
    input  data_t    i_dispatch_src_data [0:1],
    input  logic     i_dispatch_src_rdy  [0:1],
    input  rob_tag_t i_dispatch_dst_tag,
    output logic     o_dispatch_stall,

    // Result broadcast buses
    input  logic     i_cdb_en   [0:CDB_DEPTH-1],
    input  rob_tag_t i_cdb_tag  [0:CDB_DEPTH-1],
    input  data_t    i_cdb_data [0:CDB_DEPTH-1],

    // Issue to the functional unit
    input  logic     i_issue_stall,
    output logic     o_issue_valid,
    output opcode_t  o_issue_opcode,
    output addr_t    o_issue_iaddr,
    output data_t    o_issue_insn,
    output data_t    o_issue_src_data [0:1],
    output rob_tag_t o_issue_dst_tag
);

    // Per-entry status and payload gathered for the allocator and selector
    rs_mask_t entry_empty;
    rs_mask_t entry_ready;
    rs_idx_t  entry_age      [0:RS_DEPTH-1];
    opcode_t  entry_opcode   [0:RS_DEPTH-1];
    addr_t    entry_iaddr    [0:RS_DEPTH-1];
    data_t    entry_insn     [0:RS_DEPTH-1];
    data_t    entry_src_data [0:RS_DEPTH-1][0:1];
    rob_tag_t entry_dst_tag  [0:RS_DEPTH-1];

    // Station-wide dispatch and issue events
    rs_mask_t dispatch_sel;
    logic     dispatching;
    rs_mask_t issue_sel;
    logic     issuing;
    rs_idx_t  issue_age;

    rs_alloc u_alloc (
        .i_entry_empty    (entry_empty),
        .i_dispatch_en    (i_dispatch_en),
        .o_dispatch_sel   (dispatch_sel),
        .o_dispatching    (dispatching),
        .o_dispatch_stall (o_dispatch_stall)
    );

    rs_issue_select u_issue_select (
        .i_entry_ready    (entry_ready),
        .i_entry_age      (entry_age),
        .i_issue_stall    (i_issue_stall),
        .i_entry_opcode   (entry_opcode),
        .i_entry_iaddr    (entry_iaddr),
        .i_entry_insn     (entry_insn),
        .i_entry_src_data (entry_src_data),
        .i_entry_dst_tag  (entry_dst_tag),
        .o_issue_sel      (issue_sel),
        .o_issuing        (issuing),
        .o_issue_age      (issue_age),
        .o_issue_valid    (o_issue_valid),
        .o_issue_opcode   (o_issue_opcode),
        .o_issue_iaddr    (o_issue_iaddr),
        .o_issue_insn     (o_issue_insn),
        .o_issue_src_data (o_issue_src_data),
        .o_issue_dst_tag  (o_issue_dst_tag)
    );

    // Every entry sees the same dispatch fields and broadcasts, only its enable bits differ
    for (genvar g = 0; g < RS_DEPTH; g++) begin : g_entry
        rs_entry u_entry (
            .clk                 (clk),
            .i_arst_n            (i_arst_n),
            .i_flush             (i_flush),
            .i_dispatch_en       (dispatch_sel[g]),
            .i_dispatching       (dispatching),
            .i_issue_en          (issue_sel[g]),
            .i_issuing           (issuing),
            .i_issue_age         (issue_age),
            .i_dispatch_opcode   (i_dispatch_opcode),
            .i_dispatch_iaddr    (i_dispatch_iaddr),
            .i_dispatch_insn     (i_dispatch_insn),
            .i_dispatch_src_tag  (i_dispatch_src_tag),
            .i_dispatch_src_data (i_dispatch_src_data),
            .i_dispatch_src_rdy  (i_dispatch_src_rdy),
            .i_dispatch_dst_tag  (i_dispatch_dst_tag),
            .i_cdb_en            (i_cdb_en),
            .i_cdb_tag           (i_cdb_tag),
            .i_cdb_data          (i_cdb_data),
            .o_ready             (entry_ready[g]),
            .o_empty             (entry_empty[g]),
            .o_age               (entry_age[g]),
            .o_opcode            (entry_opcode[g]),
            .o_iaddr             (entry_iaddr[g]),
            .o_insn              (entry_insn[g]),
            .o_src_data          (entry_src_data[g]),
            .o_dst_tag           (entry_dst_tag[g])
        );
    end

endmodule

// File: verification/tb_clock_gen.sv
/*
 * Testbench clock and reset source
 * 8 ns clock, active-low reset held for the first 4 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_arst_n
);

    // Half of the 8 ns period
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // Reset drops away on a rising edge, after the flops have sampled it
    initial begin
        o_arst_n = 1'b0;
        repeat (4) @(posedge o_clk);
        o_arst_n <= 1'b1;
    end

endmodule

// File: verification/tb_reservation_station.sv
/*
 * Reservation station testbench
 * Runs a table of dispatch, broadcast, flush and issue steps and checks the issue port
 */

`timescale 1ns/1ps

module tb_reservation_station
    import rs_pkg::*;
();

    // Step kinds of the table
    localparam logic [2:0] K_DISP   = 3'd0;
    localparam logic [2:0] K_BCAST  = 3'd1;
    localparam logic [2:0] K_ISSUE  = 3'd2;
    localparam logic [2:0] K_HOLD   = 3'd3;
    localparam logic [2:0] K_FLUSH  = 3'd4;
    localparam logic [2:0] K_STATUS = 3'd5;

    // The table takes roughly 110 cycles, so this leaves about four times that
    localparam int TIMEOUT_CYCLES = 400;
    localparam int HOLD_CYCLES    = 4;

    // Dispatch rows use the instruction fields as stimulus, issue rows as expected values
    typedef struct packed {
        logic [2:0] kind;
        logic [2:0] test;
        opcode_t    opcode;
        rob_tag_t   dst_tag;
        rob_tag_t   src_tag0;
        rob_tag_t   src_tag1;
        data_t      src_data0;
        data_t      src_data1;
        logic       src_rdy0;
        logic       src_rdy1;
        logic       cdb_bus;
        rob_tag_t   cdb_tag;
        data_t      cdb_data;
        logic       exp_valid;
        logic       exp_stall;
    } step_t;

    step_t    steps[$];

    logic     clk;
    logic     arst_n;
    logic     flush;
    logic     dispatch_en;
    opcode_t  dispatch_opcode;
    addr_t    dispatch_iaddr;
    data_t    dispatch_insn;
    rob_tag_t dispatch_src_tag  [0:1];
    data_t    dispatch_src_data [0:1];
    logic     dispatch_src_rdy  [0:1];
    rob_tag_t dispatch_dst_tag;
    logic     dispatch_stall;
    logic     cdb_en   [0:CDB_DEPTH-1];
    rob_tag_t cdb_tag  [0:CDB_DEPTH-1];
    data_t    cdb_data [0:CDB_DEPTH-1];
    logic     issue_stall;
    logic     issue_valid;
    opcode_t  issue_opcode;
    addr_t    issue_iaddr;
    data_t    issue_insn;
    data_t    issue_src_data [0:1];
    rob_tag_t issue_dst_tag;

    int         cycles = 0;
    int         checks = 0;
    int         errors = 0;
    int         test_errors = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    integer     seed;
    data_t      bd;
    logic [2:0] cur_test;
    string      test_names [0:7];

    tb_clock_gen u_clock_gen (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    reservation_station UUT (
        .clk                 (clk),
        .i_arst_n            (arst_n),
        .i_flush             (flush),
        .i_dispatch_en       (dispatch_en),
        .i_dispatch_opcode   (dispatch_opcode),
        .i_dispatch_iaddr    (dispatch_iaddr),
        .i_dispatch_insn     (dispatch_insn),
        .i_dispatch_src_tag  (dispatch_src_tag),
        .i_dispatch_src_data (dispatch_src_data),
        .i_dispatch_src_rdy  (dispatch_src_rdy),
        .i_dispatch_dst_tag  (dispatch_dst_tag),
        .o_dispatch_stall    (dispatch_stall),
        .i_cdb_en            (cdb_en),
        .i_cdb_tag           (cdb_tag),
        .i_cdb_data          (cdb_data),
        .i_issue_stall       (issue_stall),
        .o_issue_valid       (issue_valid),
        .o_issue_opcode      (issue_opcode),
        .o_issue_iaddr       (issue_iaddr),
        .o_issue_insn        (issue_insn),
        .o_issue_src_data    (issue_src_data),
        .o_issue_dst_tag     (issue_dst_tag)
    );

    // Address and instruction bits follow from the destination tag, so every one is distinct
    function automatic addr_t addr_of(input rob_tag_t tag);
        return 32'h0000_4000 + {25'h0, tag, 2'b00};
    endfunction

    function automatic data_t insn_of(input opcode_t op, input rob_tag_t tag);
        return {op, 19'h0, tag, 4'h3};
    endfunction

    function automatic step_t new_step(input logic [2:0] kind, input logic [2:0] test);
        step_t s;
        s      = '0;
        s.kind = kind;
        s.test = test;
        return s;
    endfunction

    task automatic add_disp(input logic [2:0] test, input opcode_t op, input rob_tag_t dst,
                            input rob_tag_t tag0, input data_t data0, input logic rdy0,
                            input rob_tag_t tag1, input data_t data1, input logic rdy1);
        step_t s;
        s           = new_step(K_DISP, test);
        s.opcode    = op;
        s.dst_tag   = dst;
        s.src_tag0  = tag0;
        s.src_data0 = data0;
        s.src_rdy0  = rdy0;
        s.src_tag1  = tag1;
        s.src_data1 = data1;
        s.src_rdy1  = rdy1;
        steps.push_back(s);
    endtask

    // Issue and stall-hold rows carry the contents the issue port must show
    task automatic add_expect(input logic [2:0] kind, input logic [2:0] test, input opcode_t op,
                              input rob_tag_t dst, input data_t data0, input data_t data1);
        step_t s;
        s           = new_step(kind, test);
        s.opcode    = op;
        s.dst_tag   = dst;
        s.src_data0 = data0;
        s.src_data1 = data1;
        steps.push_back(s);
    endtask

    task automatic add_bcast(input logic [2:0] test, input logic bus, input rob_tag_t tag,
                             input data_t data);
        step_t s;
        s          = new_step(K_BCAST, test);
        s.cdb_bus  = bus;
        s.cdb_tag  = tag;
        s.cdb_data = data;
        steps.push_back(s);
    endtask

    task automatic add_status(input logic [2:0] test, input logic valid, input logic stall);
        step_t s;
        s           = new_step(K_STATUS, test);
        s.exp_valid = valid;
        s.exp_stall = stall;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Three ready instructions come out in dispatch order
        for (int k = 1; k <= 3; k++) begin
            add_disp(3'd1, 4'(k), 5'(k), 5'd0, 32'h1111_0000 + k, 1'b1,
                     5'd0, 32'h2222_0000 + k, 1'b1);
        end
        for (int k = 1; k <= 3; k++) begin
            add_expect(K_ISSUE, 3'd1, 4'(k), 5'(k), 32'h1111_0000 + k, 32'h2222_0000 + k);
        end
        // Older entry waits on tag 5, the younger ready one overtakes it
        add_disp(3'd2, 4'h4, 5'd4, 5'd5, 32'h0, 1'b0, 5'd30, 32'h2222_0004, 1'b1);
        add_disp(3'd2, 4'h5, 5'd6, 5'd30, 32'h1111_0006, 1'b1, 5'd31, 32'h2222_0006, 1'b1);
        add_expect(K_ISSUE, 3'd2, 4'h5, 5'd6, 32'h1111_0006, 32'h2222_0006);
        bd = $random(seed);
        add_bcast(3'd2, 1'b0, 5'd5, bd);
        add_expect(K_ISSUE, 3'd2, 4'h4, 5'd4, bd, 32'h2222_0004);
        // Eight waiting entries fill the station, source 1 of entry k waits on tag 16+k
        for (int k = 0; k < 8; k++) begin
            add_disp(3'd3, 4'h6, 5'(8 + k), 5'd0, 32'h3333_0000 + k, 1'b1,
                     5'(16 + k), 32'h0, 1'b0);
        end
        add_status(3'd3, 1'b0, 1'b1);
        bd = $random(seed);
        add_bcast(3'd3, 1'b1, 5'd16, bd);
        add_expect(K_ISSUE, 3'd3, 4'h6, 5'd8, 32'h3333_0000, bd);
        add_status(3'd3, 1'b0, 1'b0);
        add_disp(3'd3, 4'h7, 5'd24, 5'd0, 32'h3333_0100, 1'b1, 5'd0, 32'h3333_0200, 1'b1);
        add_expect(K_ISSUE, 3'd3, 4'h7, 5'd24, 32'h3333_0100, 32'h3333_0200);
        // The last free slot takes a ready entry, then the flush drops all eight
        add_disp(3'd4, 4'h8, 5'd25, 5'd0, 32'h4444_0001, 1'b1, 5'd0, 32'h4444_0002, 1'b1);
        add_status(3'd4, 1'b1, 1'b1);
        steps.push_back(new_step(K_FLUSH, 3'd4));
        add_status(3'd4, 1'b0, 1'b0);
        add_disp(3'd4, 4'h9, 5'd26, 5'd0, 32'h4444_0003, 1'b1, 5'd0, 32'h4444_0004, 1'b1);
        add_expect(K_ISSUE, 3'd4, 4'h9, 5'd26, 32'h4444_0003, 32'h4444_0004);
        // Back-pressure keeps the port on the younger ready entry
        add_disp(3'd5, 4'hA, 5'd27, 5'd9, 32'h0, 1'b0, 5'd0, 32'h5555_0001, 1'b1);
        add_disp(3'd5, 4'hB, 5'd28, 5'd0, 32'h5555_0002, 1'b1, 5'd0, 32'h5555_0003, 1'b1);
        add_expect(K_HOLD, 3'd5, 4'hB, 5'd28, 32'h5555_0002, 32'h5555_0003);
        add_expect(K_ISSUE, 3'd5, 4'hB, 5'd28, 32'h5555_0002, 32'h5555_0003);
        add_status(3'd5, 1'b0, 1'b0);
        bd = $random(seed);
        add_bcast(3'd5, 1'b0, 5'd9, bd);
        add_expect(K_ISSUE, 3'd5, 4'hA, 5'd27, bd, 32'h5555_0001);
        // Tag 12 is broadcast, only the entry still waiting on it may take the data
        add_disp(3'd6, 4'hC, 5'd29, 5'd12, 32'h6666_0001, 1'b1, 5'd13, 32'h6666_0002, 1'b1);
        add_disp(3'd6, 4'hD, 5'd30, 5'd12, 32'h0, 1'b0, 5'd0, 32'h6666_0003, 1'b1);
        bd = $random(seed);
        add_bcast(3'd6, 1'b1, 5'd12, bd);
        add_expect(K_ISSUE, 3'd6, 4'hC, 5'd29, 32'h6666_0001, 32'h6666_0002);
        add_expect(K_ISSUE, 3'd6, 4'hD, 5'd30, bd, 32'h6666_0003);
        add_status(3'd6, 1'b0, 1'b0);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_issue_port(input step_t s);
        check_field("issue_opcode", 32'(issue_opcode), 32'(s.opcode));
        check_field("issue_iaddr", issue_iaddr, addr_of(s.dst_tag));
        check_field("issue_insn", issue_insn, insn_of(s.opcode, s.dst_tag));
        check_field("issue_src_data[0]", issue_src_data[0], s.src_data0);
        check_field("issue_src_data[1]", issue_src_data[1], s.src_data1);
        check_field("issue_dst_tag", 32'(issue_dst_tag), 32'(s.dst_tag));
    endtask

    task automatic do_dispatch(input step_t s);
        @(posedge clk);
        dispatch_en          <= 1'b1;
        dispatch_opcode      <= s.opcode;
        dispatch_iaddr       <= addr_of(s.dst_tag);
        dispatch_insn        <= insn_of(s.opcode, s.dst_tag);
        dispatch_src_tag[0]  <= s.src_tag0;
        dispatch_src_tag[1]  <= s.src_tag1;
        dispatch_src_data[0] <= s.src_data0;
        dispatch_src_data[1] <= s.src_data1;
        dispatch_src_rdy[0]  <= s.src_rdy0;
        dispatch_src_rdy[1]  <= s.src_rdy1;
        dispatch_dst_tag     <= s.dst_tag;
        // Request stays up until a cycle without stall, the write lands at the next edge
        @(negedge clk);
        while (dispatch_stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        dispatch_en <= 1'b0;
    endtask

    task automatic do_broadcast(input step_t s);
        @(posedge clk);
        cdb_en[s.cdb_bus]   <= 1'b1;
        cdb_tag[s.cdb_bus]  <= s.cdb_tag;
        cdb_data[s.cdb_bus] <= s.cdb_data;
        @(posedge clk);
        cdb_en[s.cdb_bus]   <= 1'b0;
    endtask

    // Stall is released for exactly one cycle, so the entry is taken once
    task automatic do_issue(input step_t s);
        @(posedge clk);
        @(negedge clk);
        while (!issue_valid) begin
            @(negedge clk);
        end
        check_issue_port(s);
        @(posedge clk);
        issue_stall <= 1'b0;
        @(posedge clk);
        issue_stall <= 1'b1;
    endtask

    task automatic do_hold(input step_t s);
        @(posedge clk);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_field("issue_valid", 32'(issue_valid), 32'd1);
            check_issue_port(s);
        end
    endtask

    task automatic do_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic do_status(input step_t s);
        @(posedge clk);
        @(negedge clk);
        check_field("issue_valid", 32'(issue_valid), 32'(s.exp_valid));
        check_field("dispatch_stall", 32'(dispatch_stall), 32'(s.exp_stall));
    endtask

    task automatic report_test(input logic [2:0] test);
        if (test_errors == 0) begin
            $display("Test %0d, %s: passed", test, test_names[test]);
            tests_passed++;
        end else begin
            $display("Test %0d, %s: %0d mismatches", test, test_names[test], test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the step table did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        flush       = 1'b0;
        dispatch_en = 1'b0;
        dispatch_opcode  = '0;
        dispatch_iaddr   = '0;
        dispatch_insn    = '0;
        dispatch_dst_tag = '0;
        for (int i = 0; i < 2; i++) begin
            dispatch_src_tag[i]  = '0;
            dispatch_src_data[i] = '0;
            dispatch_src_rdy[i]  = 1'b0;
        end
        for (int c = 0; c < CDB_DEPTH; c++) begin
            cdb_en[c]   = 1'b0;
            cdb_tag[c]  = '0;
            cdb_data[c] = '0;
        end
        // The functional unit holds off by default, issue rows open it for one cycle
        issue_stall = 1'b1;
        test_names[1] = "in-order issue of ready instructions";
        test_names[2] = "wakeup of a waiting source";
        test_names[3] = "dispatch stall when full";
        test_names[4] = "flush with pending entries";
        test_names[5] = "issue back-pressure";
        test_names[6] = "ready source ignores broadcast";
        seed = 32'h1c08;
        build_table();
        wait (arst_n === 1'b1);
        cur_test = steps[0].test;
        foreach (steps[i]) begin
            if (steps[i].test != cur_test) begin
                report_test(cur_test);
                cur_test = steps[i].test;
            end
            case (steps[i].kind)
                K_DISP:   do_dispatch(steps[i]);
                K_BCAST:  do_broadcast(steps[i]);
                K_ISSUE:  do_issue(steps[i]);
                K_HOLD:   do_hold(steps[i]);
                K_FLUSH:  do_flush();
                default:  do_status(steps[i]);
            endcase
        end
        report_test(cur_test);
        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d mismatches",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: reservation_station.f
verilog/rs_pkg.sv
verilog/rs_entry.sv
verilog/rs_alloc.sv
verilog/rs_issue_select.sv
verilog/reservation_station.sv
verification/tb_clock_gen.sv
verification/tb_reservation_station.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -sv --timescale 1ns/1ps \
    --top-module tb_reservation_station \
    -Mdir obj_dir -f reservation_station.f

out=$(./obj_dir/Vtb_reservation_station)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
